// File: tm1637_cfg.svh
`ifndef TM1637_CFG_SVH
`define TM1637_CFG_SVH

// Step ROM geometry.
`define STEP_ADDR_WIDTH 4       // 16 steps in the program.
`define STEP_TIME_WIDTH 24      // Start time field and elapsed counter.
`define REPEAT_WIDTH    15      // repeat_hi and tx_data joined.

// Write flag sits at bit 2 of the step, which is bit 2 of repeat_hi.
`define STEP_WRITE_BIT  2

// Start time spacing between consecutive ROM steps, in clock cycles.
`define STEP_TIME_GAP   4

// TM1637 two-wire timing.
`define HALF_BIT_CYCLES 4       // Cycles per pin phase.
`define TX_BITS         8       // Data bits per byte; the ack clock follows.

// Debug board.
`define LED_COUNT       4       // Also the number of switches.

`endif

// File: tm1637_pkg.sv
`include "tm1637_cfg.svh"

package tm1637_pkg;

    // Encoded program step, 48 bits, most significant field first.
    typedef struct packed {
        logic                        backward;       // Jump back instead of forward.
        logic [2:0]                  next_offset;    // Jump distance, 0 means no jump.
        logic [3:0]                  reserved;
        logic [`STEP_TIME_WIDTH-1:0] start_time;     // Earliest elapsed time to run.
        logic [`TX_BITS-1:0]         tx_data;        // Byte to send, or low repeat bits.
        logic                        should_repeat;  // Repeat load step.
        logic [6:0]                  repeat_hi;      // High repeat bits; holds the write flag.
    } step_t;

    // Send request from the sequencer to the serializer.
    typedef struct packed {
        logic                start;  // One cycle strobe.
        logic [`TX_BITS-1:0] data;
    } tx_cmd_t;

    // Sequencer state for the debug LEDs.
    typedef struct packed {
        logic [`STEP_ADDR_WIDTH-1:0] step_id;
        logic                        waiting_time;  // Start time not reached yet.
        logic                        waiting_tx;    // Byte in flight.
        logic                        done;          // Program halted.
    } seq_status_t;

endpackage

// File: step_rom.sv
`timescale 1ns/1ps
`include "tm1637_cfg.svh"

module step_rom import tm1637_pkg::*; (
    input  logic [`STEP_ADDR_WIDTH-1:0] addr,
    output step_t                       step
);

    // Write step that sends one byte and may loop by an offset afterwards.
    function automatic step_t write_step(
        input int unsigned         t,
        input logic [`TX_BITS-1:0] data,
        input logic                back,
        input logic [2:0]          ofs
    );
        step_t s;
        s = '0;
        s.start_time = `STEP_TIME_WIDTH'(t);
        s.tx_data = data;
        s.backward = back;
        s.next_offset = ofs;
        s.repeat_hi[`STEP_WRITE_BIT] = 1'b1;  // Only valid with should_repeat clear.
        return s;
    endfunction

    // Repeat step with the count split over repeat_hi and tx_data.
    function automatic step_t repeat_step(
        input int unsigned              t,
        input logic [`REPEAT_WIDTH-1:0] count
    );
        step_t s;
        s = '0;
        s.start_time = `STEP_TIME_WIDTH'(t);
        s.should_repeat = 1'b1;
        {s.repeat_hi, s.tx_data} = count;
        return s;
    endfunction

    localparam int unsigned GAP = `STEP_TIME_GAP;

    // TM1637 power-on program.
    always_comb begin
        case (addr)
            `STEP_ADDR_WIDTH'd0: step = write_step(GAP * 1, 8'h40, 1'b0, 3'd0);  // Data command.
            `STEP_ADDR_WIDTH'd1: step = repeat_step(GAP * 2, 15'd3);             // Three loops back.
            `STEP_ADDR_WIDTH'd2: step = write_step(GAP * 3, 8'hc0, 1'b0, 3'd0);  // First digit.
            `STEP_ADDR_WIDTH'd3: step = write_step(GAP * 4, 8'h88, 1'b1, 3'd1);  // Dim display on.
            `STEP_ADDR_WIDTH'd4: step = write_step(GAP * 5, 8'h8f, 1'b0, 3'd0);  // Max brightness.
            default:             step = '0;  // Halt step with no write, repeat or jump.
        endcase
    end

endmodule

// File: step_sequencer.sv
`timescale 1ns/1ps
`include "tm1637_cfg.svh"

module step_sequencer import tm1637_pkg::*; (
    input  logic                        temp_clk_led,
    input  logic                        rst_n,
    input  step_t                       step,
    output logic [`STEP_ADDR_WIDTH-1:0] addr,
    output tx_cmd_t                     tx_cmd,
    input  logic                        tx_done,
    output seq_status_t                 status
);

    typedef enum logic [1:0] {
        S_WAIT_TIME,  // Wait for start time, then decode the step.
        S_ISSUE,      // Start strobe for a write step.
        S_WAIT_DONE,  // Byte on the pins.
        S_HALTED
    } seq_state_t;

    seq_state_t                  state;
    logic [`STEP_TIME_WIDTH-1:0] elapsed;
    logic [`STEP_TIME_WIDTH-1:0] saved_elapsed;  // Elapsed time at the repeat load.
    logic [`REPEAT_WIDTH-1:0]    repeat_count;
    logic                        time_reached;
    logic                        is_write;
    logic                        is_halt;
    logic                        take_jump;
    logic [`STEP_ADDR_WIDTH-1:0] offset;
    logic [`STEP_ADDR_WIDTH-1:0] jump_addr;

    assign time_reached = elapsed >= step.start_time;

    // The write flag only counts on non-repeat steps.
    assign is_write = !step.should_repeat && step.repeat_hi[`STEP_WRITE_BIT];
    assign is_halt  = !step.should_repeat && !is_write && !step.backward &&
                      (step.next_offset == 3'd0);

    // Loop only while repeats are left.
    assign take_jump = (step.next_offset != 3'd0) && (repeat_count != '0);
    assign offset    = `STEP_ADDR_WIDTH'(step.next_offset);
    assign jump_addr = step.backward ? addr - offset : addr + offset;

    always_ff @(posedge temp_clk_led) begin
        if (!rst_n) begin
            state         <= S_WAIT_TIME;
            addr          <= '0;
            elapsed       <= '0;
            saved_elapsed <= '0;
            repeat_count  <= '0;
        end else begin
            case (state)
                S_WAIT_TIME: begin
                    if (!time_reached) begin
                        elapsed <= elapsed + 1'b1;  // Count only while waiting.
                    end else if (step.should_repeat) begin
                        // Load the count and remember where the loop starts in time.
                        repeat_count  <= {step.repeat_hi, step.tx_data};
                        saved_elapsed <= elapsed;
                        addr          <= addr + 1'b1;
                    end else if (is_write) begin
                        state <= S_ISSUE;
                    end else if (is_halt) begin
                        state <= S_HALTED;
                    end else begin
                        addr <= addr + 1'b1;  // Jump-only step without a write just advances.
                    end
                end
                S_ISSUE: state <= S_WAIT_DONE;  // Strobe lasts this one cycle.
                S_WAIT_DONE: begin
                    if (tx_done) begin
                        state <= S_WAIT_TIME;
                        if (take_jump) begin
                            repeat_count <= repeat_count - 1'b1;
                            elapsed      <= saved_elapsed;  // Replay the loop timing.
                            addr         <= jump_addr;
                        end else begin
                            addr <= addr + 1'b1;
                        end
                    end
                end
                default: state <= S_HALTED;  // Stays here until reset.
            endcase
        end
    end

    // The step stays on addr until the byte is done, so data is stable.
    assign tx_cmd = '{start: (state == S_ISSUE), data: step.tx_data};

    assign status = '{
        step_id:      addr,
        waiting_time: (state == S_WAIT_TIME) && !time_reached,
        waiting_tx:   (state == S_ISSUE) || (state == S_WAIT_DONE),
        done:         (state == S_HALTED)
    };

    // One byte outstanding at most: no new start until the serializer reports done.
    a_one_outstanding: assert property (@(posedge temp_clk_led) disable iff (!rst_n)
        tx_cmd.start |=> (!tx_cmd.start throughout tx_done[->1]))
        else $error("start raised while a byte is outstanding");

endmodule

// File: tm1637_byte_tx.sv
`timescale 1ns/1ps
`include "tm1637_cfg.svh"

module tm1637_byte_tx import tm1637_pkg::*; (
    input  logic    temp_clk_led,
    input  logic    rst_n,
    input  tx_cmd_t tx_cmd,
    output logic    tx_done,
    output logic    busy,
    output logic    tm1637_clk,
    output logic    tm1637_dio
);

    localparam int                   DIV_WIDTH = $clog2(`HALF_BIT_CYCLES + 1);
    localparam logic [DIV_WIDTH-1:0] DIV_LAST  = DIV_WIDTH'(`HALF_BIT_CYCLES - 1);
    localparam logic [3:0]           ACK_BIT   = 4'(`TX_BITS);  // Ninth clock index.

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,      // Data low, clock high.
        TX_LOW,        // Clock low, data changes on the first cycle.
        TX_HIGH,       // Clock high, data sampled by the chip.
        TX_STOP_LOW,   // Pull data low for the stop.
        TX_STOP_HIGH,  // Clock back high.
        TX_STOP_END    // Data released, idle gap before done.
    } tx_state_t;

    tx_state_t            state;
    logic [DIV_WIDTH-1:0] div_cnt;  // Cycle within the current pin phase.
    logic [3:0]           bit_cnt;  // 0..7 data, 8 ack.
    logic [`TX_BITS-1:0]  shift_reg;
    logic                 phase_first;
    logic                 phase_end;

    assign phase_first = (div_cnt == '0);
    assign phase_end   = (div_cnt == DIV_LAST);
    assign busy        = (state != TX_IDLE);

    // Only one pin moves on any edge, so start and stop never look ambiguous.
    always_ff @(posedge temp_clk_led) begin
        if (!rst_n) begin
            state      <= TX_IDLE;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            tm1637_clk <= 1'b1;  // Bus idles high.
            tm1637_dio <= 1'b1;
            tx_done    <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            div_cnt <= (state == TX_IDLE || phase_end) ? '0 : div_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    if (tx_cmd.start) begin
                        tm1637_dio <= 1'b0;  // Start: data falls, clock high.
                        bit_cnt    <= '0;
                        state      <= TX_START;
                    end
                end
                TX_START: begin
                    if (phase_end) begin
                        tm1637_clk <= 1'b0;
                        state      <= TX_LOW;
                    end
                end
                TX_LOW: begin
                    if (phase_first)
                        tm1637_dio <= shift_reg[0];  // LSB first; ones after eight shifts.
                    if (phase_end) begin
                        tm1637_clk <= 1'b1;
                        state      <= TX_HIGH;
                    end
                end
                TX_HIGH: begin
                    if (phase_end) begin
                        tm1637_clk <= 1'b0;
                        if (bit_cnt == ACK_BIT) begin
                            state <= TX_STOP_LOW;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state   <= TX_LOW;
                        end
                    end
                end
                TX_STOP_LOW: begin
                    if (phase_first)
                        tm1637_dio <= 1'b0;
                    if (phase_end) begin
                        tm1637_clk <= 1'b1;
                        state      <= TX_STOP_HIGH;
                    end
                end
                TX_STOP_HIGH: begin
                    if (phase_end) begin
                        tm1637_dio <= 1'b1;  // Stop: data rises, clock high.
                        state      <= TX_STOP_END;
                    end
                end
                TX_STOP_END: begin
                    if (phase_end) begin
                        tx_done <= 1'b1;
                        state   <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Shift in ones so the ack clock sees data released.
    always_ff @(posedge temp_clk_led) begin
        if (state == TX_IDLE && tx_cmd.start)
            shift_reg <= tx_cmd.data;
        else if (state == TX_HIGH && phase_end)
            shift_reg <= {1'b1, shift_reg[`TX_BITS-1:1]};
    end

    a_done_pulse: assert property (@(posedge temp_clk_led) disable iff (!rst_n)
        tx_done |=> !tx_done)
        else $error("tx_done longer than one cycle");

    // The sequencer has no back-pressure, so a start must find us idle.
    a_start_idle: assert property (@(posedge temp_clk_led) disable iff (!rst_n)
        tx_cmd.start |-> !busy)
        else $error("start while a byte is in flight");

endmodule

// File: debug_led_mux.sv
`timescale 1ns/1ps
`include "tm1637_cfg.svh"

module debug_led_mux import tm1637_pkg::*; (
    input  logic                  rst_n,
    input  logic [`LED_COUNT-1:0] switches,  // Active low, switch 0 is the top bit.
    input  seq_status_t           status,
    input  logic                  busy,
    input  logic                  tm1637_clk,
    input  logic                  tm1637_dio,
    output logic [`LED_COUNT-1:0] led        // Active low, reversed order.
);

    logic [`LED_COUNT-1:0] norm_sw;
    logic [`LED_COUNT-1:0] shown;  // Value to display, 1 means lit.

    // Down is 0, up is 1; switch 0 becomes the most significant bit.
    always_comb begin
        for (int i = 0; i < `LED_COUNT; i++)
            norm_sw[i] = ~switches[`LED_COUNT-1-i];
    end

    always_comb begin
        case (norm_sw)
            'd0:     shown = `LED_COUNT'(status.step_id);
            'd1:     shown = {tm1637_clk, ~tm1637_clk, tm1637_dio, ~tm1637_dio};  // Pin pairs.
            'd2:     shown = {status.waiting_time, status.waiting_tx, busy, status.done};
            default: shown = norm_sw;  // Echo the switches.
        endcase
    end

    // All LEDs lit in reset; otherwise inverted and bit reversed onto the pins.
    always_comb begin
        led = '0;
        if (rst_n) begin
            for (int i = 0; i < `LED_COUNT; i++)
                led[i] = ~shown[`LED_COUNT-1-i];
        end
    end

endmodule

// File: tm1637_init_top.sv
`timescale 1ns/1ps
`include "tm1637_cfg.svh"

module tm1637_init_top import tm1637_pkg::*; (
    input  logic                  temp_clk_led,
    input  logic                  rst_n,
    input  logic [`LED_COUNT-1:0] switches,
    output logic                  tm1637_clk,
    output logic                  tm1637_dio,
    output logic [`LED_COUNT-1:0] led
);

    logic [`STEP_ADDR_WIDTH-1:0] addr;     // Current step index.
    step_t                       step;     // Step at addr, same cycle.
    tx_cmd_t                     tx_cmd;
    logic                        tx_done;
    logic                        busy;
    seq_status_t                 status;

    step_rom u_rom (
        .addr (addr),
        .step (step)
    );

    step_sequencer u_seq (
        .temp_clk_led (temp_clk_led),
        .rst_n        (rst_n),
        .step         (step),
        .addr         (addr),
        .tx_cmd       (tx_cmd),
        .tx_done      (tx_done),
        .status       (status)
    );

    tm1637_byte_tx u_tx (
        .temp_clk_led (temp_clk_led),
        .rst_n        (rst_n),
        .tx_cmd       (tx_cmd),
        .tx_done      (tx_done),
        .busy         (busy),
        .tm1637_clk   (tm1637_clk),
        .tm1637_dio   (tm1637_dio)
    );

    // Reads back the pins it drives, for the pin view on the LEDs.
    debug_led_mux u_led (
        .rst_n      (rst_n),
        .switches   (switches),
        .status     (status),
        .busy       (busy),
        .tm1637_clk (tm1637_clk),
        .tm1637_dio (tm1637_dio),
        .led        (led)
    );

endmodule

// File: tb_tm1637_init.sv
`timescale 1ns/1ps
`include "tm1637_cfg.svh"

module tb_tm1637_init;

    localparam int NUM_BYTES      = 10;    // Bytes the power-on program sends.
    localparam int BYTE_CYCLES    = 100;   // Rough cost of one framed byte plus step gap.
    localparam int TIMEOUT_CYCLES = NUM_BYTES * BYTE_CYCLES * 20;  // Far beyond the run.
    localparam int QUIET_CYCLES   = 2 * BYTE_CYCLES;  // Watch for traffic after the halt.
    localparam int NUM_RANDOM     = 4;
    localparam int RESET_CYCLES   = 16;    // Rising edges that see rst_n low.

    logic                  temp_clk_led;
    logic                  rst_n;
    logic [`LED_COUNT-1:0] switches;
    logic                  tm1637_clk;
    logic                  tm1637_dio;
    logic [`LED_COUNT-1:0] led;

    int value_errors    = 0;
    int protocol_errors = 0;
    int cycle_count     = 0;
    logic halted        = 1'b0;  // Set once the status view shows done.

    // Pin decoder state.
    logic                prev_clk = 1'b1;
    logic                prev_dio = 1'b1;
    logic                in_frame = 1'b0;
    int                  clk_edges = 0;  // Clock rises in the frame, including the stop rise.
    logic [`TX_BITS-1:0] cur_byte;
    logic [`TX_BITS-1:0] rx_bytes[$];
    logic [`TX_BITS-1:0] exp_bytes[$];

    // LED table of names, normalized switch values and expected pins.
    string                 test_names[$];
    logic [`LED_COUNT-1:0] norm_vals[$];
    logic [`LED_COUNT-1:0] exp_leds[$];

    tm1637_init_top uut (
        .temp_clk_led (temp_clk_led),
        .rst_n        (rst_n),
        .switches     (switches),
        .tm1637_clk   (tm1637_clk),
        .tm1637_dio   (tm1637_dio),
        .led          (led)
    );

    initial begin
        temp_clk_led = 1'b0;
        forever #4 temp_clk_led = ~temp_clk_led;  // 8 ns period.
    end

    // Switches are active low and switch 0 carries the top bit of the value.
    function automatic logic [`LED_COUNT-1:0] to_switches(input logic [`LED_COUNT-1:0] norm);
        logic [`LED_COUNT-1:0] sw;
        for (int j = 0; j < `LED_COUNT; j++)
            sw[j] = ~norm[`LED_COUNT-1-j];
        return sw;
    endfunction

    // LEDs are active low and wired in reverse order.
    function automatic logic [`LED_COUNT-1:0] led_pattern(input logic [`LED_COUNT-1:0] shown);
        logic [`LED_COUNT-1:0] p;
        for (int j = 0; j < `LED_COUNT; j++)
            p[j] = ~shown[`LED_COUNT-1-j];
        return p;
    endfunction

    task automatic check_byte(input string name, input logic [`TX_BITS-1:0] exp,
                              input logic [`TX_BITS-1:0] act);
        if (act !== exp) begin
            $display("Fail %s: expected 0x%02h, actual 0x%02h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_led(input string name, input logic [`LED_COUNT-1:0] exp,
                             input logic [`LED_COUNT-1:0] act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic protocol_error(input string msg);
        $display("Error: %s at %0t", msg, $time);
        protocol_errors++;
    endtask

    task automatic add_entry(input string name, input logic [`LED_COUNT-1:0] norm,
                             input logic [`LED_COUNT-1:0] shown);
        test_names.push_back(name);
        norm_vals.push_back(norm);
        exp_leds.push_back(led_pattern(shown));
    endtask

    // Pins move on rising edges and are read settled on falling edges.
    always @(negedge temp_clk_led) begin
        if (rst_n) begin
            if (tm1637_clk && prev_clk && prev_dio && !tm1637_dio) begin
                if (in_frame)
                    protocol_error("start condition inside a frame");
                in_frame  = 1'b1;  // Start.
                clk_edges = 0;
                cur_byte  = '0;
            end else if (tm1637_clk && prev_clk && !prev_dio && tm1637_dio) begin
                if (!in_frame)
                    protocol_error("stop condition without a start");
                else if (clk_edges != `TX_BITS + 2)
                    protocol_error($sformatf("frame had %0d clock rises instead of %0d",
                                             clk_edges, `TX_BITS + 2));
                else
                    rx_bytes.push_back(cur_byte);
                in_frame = 1'b0;
            end else if (tm1637_clk && !prev_clk) begin
                if (!in_frame)
                    protocol_error("clock pulse outside a frame");
                else if (clk_edges < `TX_BITS)
                    cur_byte[clk_edges] = tm1637_dio;  // LSB first.
                else if (clk_edges == `TX_BITS && !tm1637_dio)
                    protocol_error("data not released during the ack clock");
                else if (clk_edges == `TX_BITS + 1 && tm1637_dio)
                    protocol_error("data high at the clock rise before the stop");
                else if (clk_edges > `TX_BITS + 1)
                    protocol_error("extra clock pulse in a frame");
                clk_edges++;
            end
            if (halted && (tm1637_clk !== prev_clk || tm1637_dio !== prev_dio))
                protocol_error("pin traffic after the program halted");
        end
        prev_clk = tm1637_clk;
        prev_dio = tm1637_dio;
    end

    // Watchdog.
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge temp_clk_led);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        int                    seed_dummy;
        logic [`LED_COUNT-1:0] rnd;
        rst_n    = 1'b0;
        switches = to_switches(4'd2);  // Status view while the program runs.
        seed_dummy = $urandom(32'hdca49f21);

        // Data command, then address and display control four times, then brightness.
        exp_bytes.push_back(8'h40);
        repeat (4) begin
            exp_bytes.push_back(8'hc0);
            exp_bytes.push_back(8'h88);
        end
        exp_bytes.push_back(8'h8f);

        add_entry("step_view", 4'd0, 4'd5);        // Halt step.
        add_entry("pin_view", 4'd1, 4'b1010);      // Idle pins with clk and dio high.
        add_entry("status_view", 4'd2, 4'b0001);   // Only done.
        for (int k = 0; k < NUM_RANDOM; k++) begin
            rnd = 4'd3 + 4'($urandom % 13);
            add_entry($sformatf("echo_%0d", k), rnd, rnd);
        end

        for (int k = 0; k < RESET_CYCLES - 1; k++) begin
            @(posedge temp_clk_led);
            if (k == 8)
                switches <= to_switches(4'd9);  // LEDs stay lit whatever the switches say.
            @(negedge temp_clk_led);
            check_led("reset_led", '0, led);
            if (tm1637_clk !== 1'b1 || tm1637_dio !== 1'b1) begin
                $display("Fail reset_pins: expected clk=1 dio=1, actual clk=%b dio=%b",
                         tm1637_clk, tm1637_dio);
                value_errors++;
            end
        end
        @(posedge temp_clk_led);
        rst_n    <= 1'b1;
        switches <= to_switches(4'd2);

        // Done is the only lit status LED once the sequencer halts.
        @(negedge temp_clk_led);
        while (led !== led_pattern(4'b0001))
            @(negedge temp_clk_led);
        halted = 1'b1;
        repeat (QUIET_CYCLES) @(negedge temp_clk_led);

        if (in_frame)
            protocol_error("frame left open at the halt");
        if (rx_bytes.size() != exp_bytes.size()) begin
            $display("Fail byte_count: expected %0d, actual %0d",
                     exp_bytes.size(), rx_bytes.size());
            value_errors++;
        end
        for (int k = 0; k < exp_bytes.size() && k < rx_bytes.size(); k++)
            check_byte($sformatf("byte_%0d", k), exp_bytes[k], rx_bytes[k]);

        for (int k = 0; k < test_names.size(); k++) begin
            @(posedge temp_clk_led);
            switches <= to_switches(norm_vals[k]);
            @(negedge temp_clk_led);
            check_led(test_names[k], exp_leds[k], led);
        end

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: project.f
+incdir+.
tm1637_pkg.sv
step_rom.sv
step_sequencer.sv
tm1637_byte_tx.sv
debug_led_mux.sv
tm1637_init_top.sv
tb_tm1637_init.sv
